// File: hw/rv32_macros.svh
/* Opcode, funct3 and width constants for the RV32I executor,
   plus the reset program counter */
`ifndef RV32_MACROS_SVH
`define RV32_MACROS_SVH

`define RV32_XLEN        32
`define RV32_REG_ADDR_W  5
`define RV32_RESET_PC    32'h0000_0000

`define RV32_OP_LUI      7'b0110111
`define RV32_OP_AUIPC    7'b0010111
`define RV32_OP_JAL      7'b1101111
`define RV32_OP_JALR     7'b1100111
`define RV32_OP_BRANCH   7'b1100011
`define RV32_OP_LOAD     7'b0000011
`define RV32_OP_STORE    7'b0100011
`define RV32_OP_ALU      7'b0110011
`define RV32_OP_ALUI     7'b0010011

// Branch conditions
`define RV32_F3_BEQ      3'b000
`define RV32_F3_BNE      3'b001
`define RV32_F3_BLT      3'b100
`define RV32_F3_BGE      3'b101
`define RV32_F3_BLTU     3'b110
`define RV32_F3_BGEU     3'b111

// Load and store widths
`define RV32_F3_B        3'b000
`define RV32_F3_H        3'b001
`define RV32_F3_W        3'b010
`define RV32_F3_BU       3'b100
`define RV32_F3_HU       3'b101

`endif

// File: hw/rv32_pkg.sv
/* Instruction format union, ALU op codes, data-bus request,
   retire record and decoder bundle */
`include "rv32_macros.svh"

package rv32_pkg;

	typedef struct packed {
		logic [6:0]                  funct7;
		logic [`RV32_REG_ADDR_W-1:0] rs2, rs1;
		logic [2:0]                  funct3;
		logic [`RV32_REG_ADDR_W-1:0] rd;
		logic [6:0]                  opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0]                 imm;
		logic [`RV32_REG_ADDR_W-1:0] rs1;
		logic [2:0]                  funct3;
		logic [`RV32_REG_ADDR_W-1:0] rd;
		logic [6:0]                  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0]                  imm_11_5;
		logic [`RV32_REG_ADDR_W-1:0] rs2, rs1;
		logic [2:0]                  funct3;
		logic [4:0]                  imm_4_0;
		logic [6:0]                  opcode;
	} s_fmt_t;

	typedef struct packed {
		logic                        imm_12;
		logic [5:0]                  imm_10_5;
		logic [`RV32_REG_ADDR_W-1:0] rs2, rs1;
		logic [2:0]                  funct3;
		logic [3:0]                  imm_4_1;
		logic                        imm_11;
		logic [6:0]                  opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0]                 imm;
		logic [`RV32_REG_ADDR_W-1:0] rd;
		logic [6:0]                  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic                        imm_20;
		logic [9:0]                  imm_10_1;
		logic                        imm_11;
		logic [7:0]                  imm_19_12;
		logic [`RV32_REG_ADDR_W-1:0] rd;
		logic [6:0]                  opcode;
	} j_fmt_t;

	// One word, six views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		s_fmt_t s;
		b_fmt_t b;
		u_fmt_t u;
		j_fmt_t j;
	} insn_t;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
	} alu_op_e;

	typedef struct packed {
		logic                  valid;
		logic [`RV32_XLEN-1:0] addr;
		logic [`RV32_XLEN-1:0] wdata;
		logic [3:0]            wstrb;  // Low lanes only
		logic [3:0]            rmask;
	} mem_req_t;

	typedef struct packed {
		logic                        we;
		logic [`RV32_REG_ADDR_W-1:0] rd;
		logic [`RV32_XLEN-1:0]       wdata;
	} retire_t;

	typedef struct packed {
		logic                        legal;
		logic [`RV32_REG_ADDR_W-1:0] rs1, rs2;  // Zero when not read
		logic [`RV32_REG_ADDR_W-1:0] rd;
		logic                        rd_we;
		logic [`RV32_XLEN-1:0]       imm;
		logic                        use_imm;
		alu_op_e                     alu_op;
		logic                        is_load, is_store, is_branch;
		logic                        is_jal, is_jalr, is_lui, is_auipc;
		logic [2:0]                  funct3;
	} decode_t;

endpackage

// File: hw/insn_decoder.sv
/* RV32I decoder: field and immediate extraction, legality check
   and operand selection */
`timescale 1ns/100ps
`include "rv32_macros.svh"

module insn_decoder (
	input  rv32_pkg::insn_t   insn,
	input  logic              insn_valid,
	output rv32_pkg::decode_t dec
);
	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic                  base_f7;
	logic                  alt_f7;
	logic [`RV32_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic                  ok;
	logic                  live;
	rv32_pkg::decode_t     d;

	assign opcode  = insn.r.opcode;
	assign funct3  = insn.r.funct3;
	assign base_f7 = (insn.r.funct7 == 7'b0000000);
	assign alt_f7  = (insn.r.funct7 == 7'b0100000);  // SUB and SRA

	assign imm_i = {{20{insn.i.imm[11]}}, insn.i.imm};
	assign imm_s = {{20{insn.s.imm_11_5[6]}}, insn.s.imm_11_5, insn.s.imm_4_0};
	assign imm_b = {{19{insn.b.imm_12}}, insn.b.imm_12, insn.b.imm_11,
		insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
	assign imm_u = {insn.u.imm, 12'b0};
	assign imm_j = {{11{insn.j.imm_20}}, insn.j.imm_20, insn.j.imm_19_12,
		insn.j.imm_11, insn.j.imm_10_1, 1'b0};

	always_comb begin
		d        = '0;
		d.alu_op = rv32_pkg::ALU_ADD;
		d.rd     = insn.r.rd;
		d.funct3 = funct3;
		ok       = 1'b0;
		case (opcode)
			`RV32_OP_LUI, `RV32_OP_AUIPC: begin
				ok         = 1'b1;
				d.rd_we    = 1'b1;
				d.imm      = imm_u;
				d.is_lui   = (opcode == `RV32_OP_LUI);
				d.is_auipc = (opcode == `RV32_OP_AUIPC);
			end
			`RV32_OP_JAL: begin
				ok       = 1'b1;
				d.rd_we  = 1'b1;
				d.imm    = imm_j;
				d.is_jal = 1'b1;
			end
			`RV32_OP_JALR: begin
				ok        = (funct3 == 3'b000);
				d.rs1     = insn.r.rs1;
				d.rd_we   = 1'b1;
				d.imm     = imm_i;
				d.is_jalr = 1'b1;
			end
			`RV32_OP_BRANCH: begin
				ok          = (funct3 != 3'b010) && (funct3 != 3'b011);
				d.rs1       = insn.r.rs1;
				d.rs2       = insn.r.rs2;
				d.imm       = imm_b;
				d.is_branch = 1'b1;
			end
			`RV32_OP_LOAD: begin
				ok        = funct3 inside {`RV32_F3_B, `RV32_F3_H, `RV32_F3_W,
					`RV32_F3_BU, `RV32_F3_HU};
				d.rs1     = insn.r.rs1;
				d.rd_we   = 1'b1;
				d.imm     = imm_i;
				d.is_load = 1'b1;
			end
			`RV32_OP_STORE: begin
				ok         = funct3 inside {`RV32_F3_B, `RV32_F3_H, `RV32_F3_W};
				d.rs1      = insn.s.rs1;
				d.rs2      = insn.s.rs2;
				d.imm      = imm_s;
				d.is_store = 1'b1;
			end
			`RV32_OP_ALU, `RV32_OP_ALUI: begin
				d.use_imm = (opcode == `RV32_OP_ALUI);
				d.rs1     = insn.r.rs1;
				d.rs2     = d.use_imm ? '0 : insn.r.rs2;
				d.rd_we   = 1'b1;
				d.imm     = imm_i;
				ok        = d.use_imm || base_f7;  // funct7 is don't-care for most ALUI
				case (funct3)
					3'b000: begin
						d.alu_op = (!d.use_imm && alt_f7) ? rv32_pkg::ALU_SUB : rv32_pkg::ALU_ADD;
						ok       = d.use_imm || base_f7 || alt_f7;
					end
					3'b001: begin
						d.alu_op = rv32_pkg::ALU_SLL;
						ok       = base_f7;  // Shift amount is only five bits
					end
					3'b010: d.alu_op = rv32_pkg::ALU_SLT;
					3'b011: d.alu_op = rv32_pkg::ALU_SLTU;
					3'b100: d.alu_op = rv32_pkg::ALU_XOR;
					3'b101: begin
						d.alu_op = alt_f7 ? rv32_pkg::ALU_SRA : rv32_pkg::ALU_SRL;
						ok       = base_f7 || alt_f7;
					end
					3'b110: d.alu_op = rv32_pkg::ALU_OR;
					default: d.alu_op = rv32_pkg::ALU_AND;
				endcase
			end
			default: ok = 1'b0;
		endcase
	end

	assign live = insn_valid && ok;

	// Side effects only for a valid legal instruction
	always_comb begin
		dec           = d;
		dec.legal     = ok;
		dec.rd_we     = live && d.rd_we && (d.rd != '0);
		dec.is_load   = live && d.is_load;
		dec.is_store  = live && d.is_store;
		dec.is_branch = live && d.is_branch;
		dec.is_jal    = live && d.is_jal;
		dec.is_jalr   = live && d.is_jalr;
		dec.is_lui    = live && d.is_lui;
		dec.is_auipc  = live && d.is_auipc;
	end

endmodule

// File: hw/alu_unit.sv
/* Integer ALU with the compare flags used for branches */
`timescale 1ns/100ps
`include "rv32_macros.svh"

module alu_unit (
	input  rv32_pkg::alu_op_e     op,
	input  logic [`RV32_XLEN-1:0] a,
	input  logic [`RV32_XLEN-1:0] b,
	output logic [`RV32_XLEN-1:0] result,
	output logic                  lt,
	output logic                  ltu,
	output logic                  eq
);
	logic [4:0] shamt;

	assign shamt = b[4:0];  // Upper bits ignored
	assign lt    = $signed(a) < $signed(b);
	assign ltu   = a < b;
	assign eq    = (a == b);

	always_comb begin
		case (op)
			rv32_pkg::ALU_ADD:  result = a + b;
			rv32_pkg::ALU_SUB:  result = a - b;
			rv32_pkg::ALU_SLL:  result = a << shamt;
			rv32_pkg::ALU_SLT:  result = {{(`RV32_XLEN-1){1'b0}}, lt};
			rv32_pkg::ALU_SLTU: result = {{(`RV32_XLEN-1){1'b0}}, ltu};
			rv32_pkg::ALU_XOR:  result = a ^ b;
			rv32_pkg::ALU_SRL:  result = a >> shamt;
			rv32_pkg::ALU_SRA:  result = $signed(a) >>> shamt;  // Sign fill
			rv32_pkg::ALU_OR:   result = a | b;
			default:            result = a & b;
		endcase
	end

endmodule

// File: hw/load_store_unit.sv
/* Data-bus request forming and load data extension */
`timescale 1ns/100ps
`include "rv32_macros.svh"

module load_store_unit (
	input  rv32_pkg::decode_t     dec,
	input  logic [`RV32_XLEN-1:0] rs1_val,
	input  logic [`RV32_XLEN-1:0] rs2_val,
	output rv32_pkg::mem_req_t    mem_req,
	input  logic [`RV32_XLEN-1:0] mem_rdata,
	output logic [`RV32_XLEN-1:0] load_data
);
	logic [3:0] mask;

	// Byte lanes from the access width
	always_comb begin
		case (dec.funct3)
			`RV32_F3_B, `RV32_F3_BU: mask = 4'b0001;
			`RV32_F3_H, `RV32_F3_HU: mask = 4'b0011;
			default:                 mask = 4'b1111;
		endcase
	end

	always_comb begin
		mem_req.valid = dec.is_load || dec.is_store;
		mem_req.addr  = rs1_val + dec.imm;  // Full byte address
		mem_req.wdata = dec.is_store ? rs2_val : '0;
		mem_req.wstrb = dec.is_store ? mask : 4'b0000;
		mem_req.rmask = dec.is_load ? mask : 4'b0000;
	end

	always_comb begin
		case (dec.funct3)
			`RV32_F3_B:  load_data = {{24{mem_rdata[7]}}, mem_rdata[7:0]};
			`RV32_F3_BU: load_data = {24'b0, mem_rdata[7:0]};
			`RV32_F3_H:  load_data = {{16{mem_rdata[15]}}, mem_rdata[15:0]};
			`RV32_F3_HU: load_data = {16'b0, mem_rdata[15:0]};
			default:     load_data = mem_rdata;
		endcase
	end

endmodule

// File: hw/next_pc_unit.sv
/* Branch decision and next program counter selection */
`timescale 1ns/100ps
`include "rv32_macros.svh"

module next_pc_unit (
	input  rv32_pkg::decode_t     dec,
	input  logic [`RV32_XLEN-1:0] pc,
	input  logic [`RV32_XLEN-1:0] rs1_val,
	input  logic                  lt,
	input  logic                  ltu,
	input  logic                  eq,
	output logic [`RV32_XLEN-1:0] pc_next
);
	logic                  take;
	logic [`RV32_XLEN-1:0] jalr_sum;

	always_comb begin
		case (dec.funct3)
			`RV32_F3_BEQ:  take = eq;
			`RV32_F3_BNE:  take = !eq;
			`RV32_F3_BLT:  take = lt;
			`RV32_F3_BGE:  take = !lt;
			`RV32_F3_BLTU: take = ltu;
			`RV32_F3_BGEU: take = !ltu;
			default:       take = 1'b0;
		endcase
	end

	assign jalr_sum = rs1_val + dec.imm;

	always_comb begin
		if (!dec.legal)
			pc_next = pc;  // Trap holds the PC
		else if (dec.is_jal || (dec.is_branch && take))
			pc_next = pc + dec.imm;
		else if (dec.is_jalr)
			pc_next = {jalr_sum[`RV32_XLEN-1:1], 1'b0};
		else
			pc_next = pc + 32'd4;
	end

endmodule

// File: hw/register_file.sv
/* Integer register file, x1 to x31, x0 reads as zero */
`timescale 1ns/100ps

module register_file (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [4:0]        rs1,
	input  logic [4:0]        rs2,
	output logic [31:0]       rs1_val,
	output logic [31:0]       rs2_val,
	input  rv32_pkg::retire_t wr
);
	logic [31:0] regs [1:31];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wr.we && (wr.rd != 5'd0)) begin
			regs[wr.rd] <= wr.wdata;
		end
	end

	// Combinational read ports
	assign rs1_val = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
	assign rs2_val = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

// File: hw/rv32_exec_core.sv
/* Single-cycle RV32I executor top: program counter, register file,
   writeback selection and trap */
`timescale 1ns/100ps
`include "rv32_macros.svh"

module rv32_exec_core (
	input  logic                  clk,
	input  logic                  rst_n,
	input  rv32_pkg::insn_t       insn,
	input  logic                  insn_valid,
	output logic [`RV32_XLEN-1:0] insn_addr,
	output rv32_pkg::mem_req_t    mem_req,
	input  logic [`RV32_XLEN-1:0] mem_rdata,
	input  logic                  mem_ready,
	output rv32_pkg::retire_t     retire,
	output logic                  insn_complete,
	output logic                  trap
);
	rv32_pkg::decode_t     dec;
	logic [`RV32_XLEN-1:0] pc, pc_next, pc_plus4;
	logic [`RV32_XLEN-1:0] rs1_val, rs2_val, alu_b, alu_result;
	logic [`RV32_XLEN-1:0] load_data, wb_data;
	logic                  lt, ltu, eq;

	insn_decoder u_dec (
		.insn       (insn),
		.insn_valid (insn_valid),
		.dec        (dec)
	);

	register_file u_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs1     (dec.rs1),
		.rs2     (dec.rs2),
		.rs1_val (rs1_val),
		.rs2_val (rs2_val),
		.wr      (retire)
	);

	assign alu_b = dec.use_imm ? dec.imm : rs2_val;

	alu_unit u_alu (
		.op     (dec.alu_op),
		.a      (rs1_val),
		.b      (alu_b),
		.result (alu_result),
		.lt     (lt),
		.ltu    (ltu),
		.eq     (eq)
	);

	load_store_unit u_lsu (
		.dec       (dec),
		.rs1_val   (rs1_val),
		.rs2_val   (rs2_val),
		.mem_req   (mem_req),
		.mem_rdata (mem_rdata),
		.load_data (load_data)
	);

	next_pc_unit u_npc (
		.dec     (dec),
		.pc      (pc),
		.rs1_val (rs1_val),
		.lt      (lt),
		.ltu     (ltu),
		.eq      (eq),
		.pc_next (pc_next)
	);

	// Only a data access can stretch an instruction
	assign insn_complete = insn_valid && (!mem_req.valid || mem_ready);
	assign trap          = insn_valid && !dec.legal;
	assign pc_plus4      = pc + 32'd4;
	assign insn_addr     = pc;

	always_comb begin
		if (dec.is_load)
			wb_data = load_data;
		else if (dec.is_jal || dec.is_jalr)
			wb_data = pc_plus4;  // Link value
		else if (dec.is_lui)
			wb_data = dec.imm;
		else if (dec.is_auipc)
			wb_data = pc + dec.imm;
		else
			wb_data = alu_result;
	end

	always_comb begin
		retire.we    = dec.rd_we && insn_complete && !trap;
		retire.rd    = dec.rd;
		retire.wdata = wb_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			pc <= `RV32_RESET_PC;
		else if (insn_complete)
			pc <= pc_next;
	end

endmodule

// File: testbench/rv32_exec_chk.sv
/* Concurrent port assertions, bound into rv32_exec_core */
`timescale 1ns/100ps

module rv32_exec_chk (
	input logic               clk,
	input logic               rst_n,
	input logic               insn_valid,
	input logic [31:0]        insn_addr,
	input rv32_pkg::mem_req_t mem_req,
	input rv32_pkg::retire_t  retire,
	input logic               trap
);
	// A data request only comes with an instruction
	a_req_with_insn: assert property (@(posedge clk) disable iff (!rst_n)
		mem_req.valid |-> insn_valid)
		else $error("mem_req.valid high without insn_valid");

	a_trap_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		trap |-> (!retire.we && !mem_req.valid))
		else $error("trap with a register write or a memory request");

	a_pc_even: assert property (@(posedge clk) disable iff (!rst_n)
		!insn_addr[0])
		else $error("insn_addr bit 0 is set");

endmodule

bind rv32_exec_core rv32_exec_chk u_chk (
	.clk        (clk),
	.rst_n      (rst_n),
	.insn_valid (insn_valid),
	.insn_addr  (insn_addr),
	.mem_req    (mem_req),
	.retire     (retire),
	.trap       (trap)
);

// File: testbench/rv32_exec_tb.sv
/* RV32I executor testbench: random instruction stream, byte memory,
   architectural model and per-instruction checks */
`timescale 1ns/100ps
`include "rv32_macros.svh"

module rv32_exec_tb;
	logic               clk;
	logic               rst_n;
	rv32_pkg::insn_t    insn;
	logic               insn_valid;
	logic [31:0]        insn_addr;
	rv32_pkg::mem_req_t mem_req;
	logic [31:0]        mem_rdata;
	logic               mem_ready;
	rv32_pkg::retire_t  retire;
	logic               insn_complete;
	logic               trap;

	integer             seed = 23572;
	logic [31:0]        regs_m [0:31];  // Architectural registers
	logic [31:0]        pc_m;
	logic [7:0]         mem_m [0:255];
	logic               e_we;
	logic               e_trap;
	logic [4:0]         e_rd;
	logic [31:0]        e_wd;
	logic [31:0]        e_pc;
	rv32_pkg::mem_req_t e_req;

	rv32_exec_core UUT (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'b0, $signed(a) < $signed(b)};
			3'd3: return {31'b0, a < b};
			3'd4: return a ^ b;
			3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// Bytes in the low lanes, address wraps inside the model memory
	function automatic logic [31:0] mem_word(input logic [7:0] a);
		return {mem_m[a + 8'd3], mem_m[a + 8'd2], mem_m[a + 8'd1], mem_m[a]};
	endfunction

	function automatic logic [31:0] load_value(input logic [2:0] f3, input logic [31:0] w);
		case (f3)
			3'd0: return {{24{w[7]}}, w[7:0]};
			3'd1: return {{16{w[15]}}, w[15:0]};
			3'd4: return {24'b0, w[7:0]};
			3'd5: return {16'b0, w[15:0]};
			default: return w;
		endcase
	endfunction

	function automatic logic [3:0] lane_mask(input logic [2:0] f3);
		return (f3[1:0] == 2'd0) ? 4'b0001 : (f3[1:0] == 2'd1) ? 4'b0011 : 4'b1111;
	endfunction

	task automatic report_failure();
		$display("FAIL: see errors above");
		$fatal(1, "Stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
			report_failure();
		end
	endtask

	task automatic clear_expect();
		e_we   = 1'b0;
		e_rd   = 5'd0;
		e_wd   = 32'd0;
		e_trap = 1'b0;
		e_req  = '0;
		e_pc   = pc_m + 32'd4;
	endtask

	task automatic expect_write(input logic [4:0] rd, input logic [31:0] val);
		e_we = (rd != 5'd0);  // x0 is never written
		e_rd = rd;
		e_wd = val;
	endtask

	// Drive one instruction from a falling edge and retire it
	task automatic execute(input logic [31:0] word);
		int          stall;
		int          cyc;
		logic [31:0] r;
		r = $random(seed);
		stall = int'(r[1:0]);
		cyc = 0;
		insn = word;
		insn_valid = 1'b1;
		mem_ready = (stall == 0);
		mem_rdata = mem_word(e_req.addr[7:0]);
		#1;
		check_value("insn_complete", 32'(!e_req.valid || cyc >= stall),
			32'(insn_complete));
		while (!insn_complete) begin
			check_value("mem_req.valid", 32'd1, 32'(mem_req.valid));
			check_value("retire.we", 32'd0, 32'(retire.we));
			if (cyc == 8) begin
				$display("Error at %0t: insn_complete stayed low for 8 cycles", $time);
				report_failure();
			end
			@(negedge clk);
			cyc++;
			mem_ready = (cyc >= stall);
			#1;
			check_value("insn_complete", 32'(!e_req.valid || cyc >= stall),
				32'(insn_complete));
		end
		check_value("trap", 32'(e_trap), 32'(trap));
		check_value("mem_req.valid", 32'(e_req.valid), 32'(mem_req.valid));
		if (e_req.valid) begin
			check_value("mem_req.addr", e_req.addr, mem_req.addr);
			check_value("mem_req.rmask", 32'(e_req.rmask), 32'(mem_req.rmask));
			check_value("mem_req.wstrb", 32'(e_req.wstrb), 32'(mem_req.wstrb));
			if (e_req.wstrb != 4'b0)
				check_value("mem_req.wdata", e_req.wdata, mem_req.wdata);
		end
		check_value("retire.we", 32'(e_we), 32'(retire.we));
		if (e_we) begin
			check_value("retire.rd", 32'(e_rd), 32'(retire.rd));
			check_value("retire.wdata", e_wd, retire.wdata);
		end
		@(negedge clk);
		if (e_we)
			regs_m[e_rd] = e_wd;
		for (int i = 0; i < 4; i++)
			if (e_req.wstrb[i])
				mem_m[e_req.addr[7:0] + 8'(i)] = e_req.wdata[8*i +: 8];
		pc_m = e_pc;
		check_value("insn_addr", pc_m, insn_addr);
	endtask

	// ADDI from x0 puts a small base address into a register
	task automatic set_base(input logic [4:0] rb, input logic [31:0] val);
		clear_expect();
		expect_write(rb, val);
		execute({val[11:0], 5'd0, 3'b000, rb, `RV32_OP_ALUI});
	endtask

	task automatic random_step();
		logic [31:0] r;
		logic [31:0] s;
		logic [31:0] imm;
		logic [31:0] word;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic        alt;
		r = $random(seed);
		s = $random(seed);
		rd = r[11:7];
		rs1 = r[19:15];
		rs2 = r[24:20];
		f3 = r[14:12];
		clear_expect();
		case (s[3:0])
			4'd0: begin  // Reserved funct3 on load or branch
				e_trap = 1'b1;
				e_pc = pc_m;
				word = {r[31:15], 3'b011, r[11:7], r[0] ? `RV32_OP_LOAD : `RV32_OP_BRANCH};
			end
			4'd1, 4'd2, 4'd3, 4'd4, 4'd5: begin
				alt = s[4] && (f3 == 3'd0 || f3 == 3'd5);
				word = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, `RV32_OP_ALU};
				expect_write(rd, alu_model(f3, alt, regs_m[rs1], regs_m[rs2]));
			end
			4'd6, 4'd7, 4'd8: begin
				alt = s[4] && (f3 == 3'd5);
				imm = {{20{r[31]}}, r[31:20]};
				if (f3 == 3'd1 || f3 == 3'd5)
					imm = {20'b0, 1'b0, alt, 5'b0, r[24:20]};  // Shift amount form
				word = {imm[11:0], rs1, f3, rd, `RV32_OP_ALUI};
				expect_write(rd, alu_model(f3, alt, regs_m[rs1], imm));
			end
			4'd9: begin
				word = {r[31:12], rd, `RV32_OP_LUI};
				expect_write(rd, {r[31:12], 12'b0});
			end
			4'd10: begin
				word = {r[31:12], rd, `RV32_OP_AUIPC};
				expect_write(rd, pc_m + {r[31:12], 12'b0});
			end
			4'd11, 4'd12: begin
				if (rs1 == 5'd0)
					rs1 = 5'd1;
				set_base(rs1, {25'b0, s[30:24]} % 32'd125);
				clear_expect();
				imm = {25'b0, s[22:16]};
				e_req.valid = 1'b1;
				e_req.addr = regs_m[rs1] + imm;
				if (s[3:0] == 4'd11) begin
					if (f3 == 3'd3 || f3 > 3'd5)
						f3 = 3'd2;
					word = {imm[11:0], rs1, f3, rd, `RV32_OP_LOAD};
					e_req.rmask = lane_mask(f3);
					expect_write(rd, load_value(f3, mem_word(e_req.addr[7:0])));
				end else begin
					f3 = (f3[1:0] == 2'd3) ? 3'd2 : {1'b0, f3[1:0]};
					word = {imm[11:5], rs2, rs1, f3, imm[4:0], `RV32_OP_STORE};
					e_req.wdata = regs_m[rs2];
					e_req.wstrb = lane_mask(f3);
				end
			end
			4'd13: begin
				if (f3 == 3'd2 || f3 == 3'd3)
					f3 = {1'b1, f3[1:0]};
				word = {r[31:25], rs2, rs1, f3, r[11:7], `RV32_OP_BRANCH};
				imm = {{20{r[31]}}, r[7], r[30:25], r[11:8], 1'b0};
				if (branch_taken(f3, regs_m[rs1], regs_m[rs2]))
					e_pc = pc_m + imm;
			end
			4'd14: begin
				word = {r[31:12], rd, `RV32_OP_JAL};
				imm = {{12{r[31]}}, r[19:12], r[20], r[30:21], 1'b0};
				e_pc = pc_m + imm;
				expect_write(rd, pc_m + 32'd4);
			end
			default: begin
				word = {r[31:20], rs1, 3'b000, rd, `RV32_OP_JALR};
				imm = {{20{r[31]}}, r[31:20]};
				e_pc = (regs_m[rs1] + imm) & ~32'd1;
				expect_write(rd, pc_m + 32'd4);
			end
		endcase
		execute(word);
	endtask

	initial begin
		rst_n = 1'b0;
		insn = '0;
		insn_valid = 1'b0;
		mem_rdata = '0;
		mem_ready = 1'b0;
		for (int i = 0; i < 32; i++)
			regs_m[i[4:0]] = '0;
		for (int i = 0; i < 256; i++)
			mem_m[i[7:0]] = 8'(i * 29) ^ 8'ha5;
		pc_m = `RV32_RESET_PC;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		#1;
		check_value("insn_addr", pc_m, insn_addr);
		check_value("insn_complete", 32'd0, 32'(insn_complete));
		check_value("trap", 32'd0, 32'(trap));
		check_value("mem_req.valid", 32'd0, 32'(mem_req.valid));
		check_value("retire.we", 32'd0, 32'(retire.we));
		@(negedge clk);
		repeat (2000) random_step();
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: all.f
+incdir+hw
hw/rv32_pkg.sv
hw/insn_decoder.sv
hw/alu_unit.sv
hw/load_store_unit.sv
hw/next_pc_unit.sv
hw/register_file.sv
hw/rv32_exec_core.sv
testbench/rv32_exec_chk.sv
testbench/rv32_exec_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rv32_exec_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= FAIL: see errors above
PASS_MSG  ?= PASS: all tests
SOURCES   := $(wildcard hw/*.sv hw/*.svh testbench/*.sv)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(OBJ_DIR)/V$(TOP)
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
